//--- src/scr_pkg.sv
// Scrambling package
// Key, nonce and bank geometry, reset key material,
// and the XOR keystream rule shared by the bank

package scr_pkg;

  // Key material
  localparam int unsigned SCR_KEY_W   = 128;
  localparam int unsigned SCR_NONCE_W = 64;

  // Bank geometry
  localparam int unsigned BANK_DATA_W = 32;
  localparam int unsigned BANK_DEPTH  = 16;
  localparam int unsigned BANK_ADDR_W = 4;

  // Key and nonce in use straight out of reset
  localparam logic [SCR_KEY_W-1:0]   RST_KEY   = 128'h3c5a_9e17_d2b4_6f08_81c3_5e7a_0b9d_f246;
  localparam logic [SCR_NONCE_W-1:0] RST_NONCE = 64'h7a1e_c390_5b2d_84f6;

  //////////////////////////////////////////////////
  // Keystream
  //////////////////////////////////////////////////

  // XOR of all key words, all nonce words and the zero-extended address
  function automatic logic [BANK_DATA_W-1:0] scr_keystream(
    input logic [SCR_KEY_W-1:0]   key,
    input logic [SCR_NONCE_W-1:0] nonce,
    input logic [BANK_ADDR_W-1:0] addr
  );
    logic [BANK_DATA_W-1:0] ks;

    ks = BANK_DATA_W'(addr);
    for (int i = 0; i < SCR_KEY_W / BANK_DATA_W; i++) begin
      ks = ks ^ key[i*BANK_DATA_W +: BANK_DATA_W];
    end
    for (int j = 0; j < SCR_NONCE_W / BANK_DATA_W; j++) begin
      ks = ks ^ nonce[j*BANK_DATA_W +: BANK_DATA_W];
    end
    return ks;
  endfunction

endpackage

//--- src/scr_key_mgr.sv
// Scrambling key manager
// Key and nonce registers plus the request and valid
// handshake used to fetch a fresh key after an invalidation

`timescale 1ns/1ps

module scr_key_mgr (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  // Rekey trigger
  input  logic                             icache_inval_i,

  // New key delivery
  input  logic                             key_valid_i,
  input  logic [scr_pkg::SCR_KEY_W-1:0]    key_i,
  input  logic [scr_pkg::SCR_NONCE_W-1:0]  nonce_i,
  output logic                             scramble_req_o,

  // Key bundle towards the bank
  output logic                             key_valid_o,
  output logic [scr_pkg::SCR_KEY_W-1:0]    key_o,
  output logic [scr_pkg::SCR_NONCE_W-1:0]  nonce_o
);

  import scr_pkg::*;

  logic [SCR_KEY_W-1:0]   key_q;
  logic [SCR_NONCE_W-1:0] nonce_q;
  logic                   key_valid_d, key_valid_q;
  logic                   req_d, req_q;

  //////////////////////////////////////////////////
  // Key material
  //////////////////////////////////////////////////

  // Any delivery overwrites the key, requested or not
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q   <= RST_KEY;
      nonce_q <= RST_NONCE;
    end else if (key_valid_i) begin
      key_q   <= key_i;
      nonce_q <= nonce_i;
    end
  end

  //////////////////////////////////////////////////
  // Request and valid state
  //////////////////////////////////////////////////

  // Request held until a key shows up
  assign req_d = req_q ? ~key_valid_i : icache_inval_i;

  // Valid drops on invalidation and comes back with the requested key
  assign key_valid_d = req_q          ? key_valid_i :
                       icache_inval_i ? 1'b0        :
                                        key_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q       <= 1'b0;
      key_valid_q <= 1'b1;
    end else begin
      req_q       <= req_d;
      key_valid_q <= key_valid_d;
    end
  end

  assign scramble_req_o = req_q;
  assign key_valid_o    = key_valid_q;
  assign key_o          = key_q;
  assign nonce_o        = nonce_q;

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  // Bank stays fenced off for the whole request
  a_req_fences_key : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    req_q |-> !key_valid_q
  );

endmodule

//--- src/scr_ram_bank.sv
// Scrambled single-port data bank
// Storage array with XOR keystream scrambling on write
// and unscrambling on read, granted only with a valid key

`timescale 1ns/1ps

module scr_ram_bank (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  // Key bundle
  input  logic                             key_valid_i,
  input  logic [scr_pkg::SCR_KEY_W-1:0]    key_i,
  input  logic [scr_pkg::SCR_NONCE_W-1:0]  nonce_i,

  // Request side
  input  logic                             req_i,
  input  logic                             we_i,
  input  logic [scr_pkg::BANK_ADDR_W-1:0]  addr_i,
  input  logic [scr_pkg::BANK_DATA_W-1:0]  wdata_i,
  output logic                             gnt_o,

  // Response side
  output logic                             rvalid_o,
  output logic [scr_pkg::BANK_DATA_W-1:0]  rdata_o
);

  import scr_pkg::*;

  logic [BANK_DATA_W-1:0] mem_q [BANK_DEPTH];
  logic [BANK_DATA_W-1:0] keystream;
  logic                   wr_en;
  logic                   rd_en;
  logic                   rvalid_q;
  logic [BANK_DATA_W-1:0] rdata_q;

  //////////////////////////////////////////////////
  // Grant and keystream
  //////////////////////////////////////////////////

  // Requests made without a valid key are dropped
  assign gnt_o = req_i & key_valid_i;
  assign wr_en = gnt_o & we_i;
  assign rd_en = gnt_o & ~we_i;

  assign keystream = scr_keystream(key_i, nonce_i, addr_i);

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  // Only scrambled words ever land in the array
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[addr_i] <= wdata_i ^ keystream;
    end
  end

  // Unscramble with the key seen at the read itself
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= mem_q[addr_i] ^ keystream;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd_en;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  // Requests against an invalid key never produce a response
  a_no_rsp_invalid_key : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (req_i && !key_valid_i) |=> !rvalid_o
  );

  // Read data only ever answers a granted read one cycle back
  a_rvalid_after_read : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rvalid_o |-> $past(gnt_o && !we_i)
  );

endmodule

//--- src/scr_top.sv
// Scrambling top level
// Key manager steering the scrambled data bank,
// plus the registered busy flag behind the sleep output

`timescale 1ns/1ps

module scr_top (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  // Rekey trigger
  input  logic                             icache_inval_i,

  // Key delivery
  input  logic                             scramble_key_valid_i,
  input  logic [scr_pkg::SCR_KEY_W-1:0]    scramble_key_i,
  input  logic [scr_pkg::SCR_NONCE_W-1:0]  scramble_nonce_i,
  output logic                             scramble_req_o,

  // Bank access
  input  logic                             bank_req_i,
  input  logic                             bank_we_i,
  input  logic [scr_pkg::BANK_ADDR_W-1:0]  bank_addr_i,
  input  logic [scr_pkg::BANK_DATA_W-1:0]  bank_wdata_i,
  output logic                             bank_gnt_o,
  output logic                             bank_rvalid_o,
  output logic [scr_pkg::BANK_DATA_W-1:0]  bank_rdata_o,

  // Wake sources
  input  logic                             core_busy_i,
  input  logic                             debug_req_i,
  input  logic                             irq_pending_i,
  input  logic                             irq_nm_i,
  output logic                             core_sleep_o
);

  import scr_pkg::*;

  logic                   key_valid;
  logic [SCR_KEY_W-1:0]   key;
  logic [SCR_NONCE_W-1:0] nonce;
  logic                   core_busy_q;
  logic                   wake;

  //////////////////////////////////////////////////
  // Sleep decision
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= core_busy_i;
    end
  end

  // Debug and interrupts wake at once, busy one cycle late
  assign wake         = core_busy_q | debug_req_i | irq_pending_i | irq_nm_i;
  assign core_sleep_o = ~wake;

  //////////////////////////////////////////////////
  // Scrambling
  //////////////////////////////////////////////////

  scr_key_mgr u_key_mgr (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .icache_inval_i (icache_inval_i),
    .key_valid_i    (scramble_key_valid_i),
    .key_i          (scramble_key_i),
    .nonce_i        (scramble_nonce_i),
    .scramble_req_o (scramble_req_o),
    .key_valid_o    (key_valid),
    .key_o          (key),
    .nonce_o        (nonce)
  );

  scr_ram_bank u_bank (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .key_valid_i (key_valid),
    .key_i       (key),
    .nonce_i     (nonce),
    .req_i       (bank_req_i),
    .we_i        (bank_we_i),
    .addr_i      (bank_addr_i),
    .wdata_i     (bank_wdata_i),
    .gnt_o       (bank_gnt_o),
    .rvalid_o    (bank_rvalid_o),
    .rdata_o     (bank_rdata_o)
  );

  // Control outputs never go unknown once out of reset
  a_outputs_known : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !$isunknown({scramble_req_o, bank_gnt_o, bank_rvalid_o, core_sleep_o})
  );

endmodule

//--- sim/tb_clk_gen.sv
// Testbench clock and reset generator
// 100 ns clock, active-low reset held for four cycles

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 4;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the capturing edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

//--- sim/tb_top.sv
// Testbench top
// Replays the cases file against the scrambling top level with a
// reference model of key, nonce and raw bank words, then a random burst

`timescale 1ns/1ps

module tb_top;

  import scr_pkg::*;

  localparam logic [127:0] RESET_KEY      = 128'h3c5a_9e17_d2b4_6f08_81c3_5e7a_0b9d_f246;
  localparam logic [63:0]  RESET_NONCE    = 64'h7a1e_c390_5b2d_84f6;
  localparam int           TIMEOUT_CYCLES = 20;
  localparam int           SETTLE         = 10;

  logic                   clk;
  logic                   rst_n;
  logic                   icache_inval;
  logic                   scramble_key_valid;
  logic [SCR_KEY_W-1:0]   scramble_key;
  logic [SCR_NONCE_W-1:0] scramble_nonce;
  logic                   scramble_req;
  logic                   bank_req;
  logic                   bank_we;
  logic [BANK_ADDR_W-1:0] bank_addr;
  logic [BANK_DATA_W-1:0] bank_wdata;
  logic                   bank_gnt;
  logic                   bank_rvalid;
  logic [BANK_DATA_W-1:0] bank_rdata;
  logic                   core_busy;
  logic                   debug_req;
  logic                   irq_pending;
  logic                   irq_nm;
  logic                   core_sleep;

  // Reference model
  logic [SCR_KEY_W-1:0]   key_model;
  logic [SCR_NONCE_W-1:0] nonce_model;
  logic [BANK_DATA_W-1:0] mem_model [BANK_DEPTH];
  logic                   busy_model;
  logic [BANK_DATA_W-1:0] last_rdata;
  int                     error_count;
  int                     seed;

  tb_clk_gen i_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  scr_top i_dut (
    .clk_i                (clk),
    .rst_ni               (rst_n),
    .icache_inval_i       (icache_inval),
    .scramble_key_valid_i (scramble_key_valid),
    .scramble_key_i       (scramble_key),
    .scramble_nonce_i     (scramble_nonce),
    .scramble_req_o       (scramble_req),
    .bank_req_i           (bank_req),
    .bank_we_i            (bank_we),
    .bank_addr_i          (bank_addr),
    .bank_wdata_i         (bank_wdata),
    .bank_gnt_o           (bank_gnt),
    .bank_rvalid_o        (bank_rvalid),
    .bank_rdata_o         (bank_rdata),
    .core_busy_i          (core_busy),
    .debug_req_i          (debug_req),
    .irq_pending_i        (irq_pending),
    .irq_nm_i             (irq_nm),
    .core_sleep_o         (core_sleep)
  );

  //////////////////////////////////////////////////
  // Model and reporting
  //////////////////////////////////////////////////

  // Keystream: all key words, both nonce words and the address folded by XOR
  function automatic logic [BANK_DATA_W-1:0] xor_pad(
    input logic [SCR_KEY_W-1:0]   key,
    input logic [SCR_NONCE_W-1:0] nonce,
    input logic [BANK_ADDR_W-1:0] addr
  );
    return key[127:96] ^ key[95:64] ^ key[63:32] ^ key[31:0]
         ^ nonce[63:32] ^ nonce[31:0] ^ {28'h0, addr};
  endfunction

  task automatic abort_run(input string reason);
    $display("sim failed");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_value(input string what, input logic [127:0] got,
                             input logic [127:0] expected);
    if (got !== expected) begin
      error_count++;
      $display("ERROR at %0t: %s: got 0x%0h, expected 0x%0h", $time, what, got, expected);
      abort_run("value mismatch");
    end
  endtask

  //////////////////////////////////////////////////
  // Bus tasks, entered and left on a falling edge
  //////////////////////////////////////////////////

  task automatic wait_grant();
    int tries;

    tries = 0;
    #SETTLE;
    while (!bank_gnt) begin
      @(negedge clk);
      tries++;
      if (tries > TIMEOUT_CYCLES) begin
        abort_run("the bank never granted the request");
      end
      #SETTLE;
    end
  endtask

  // Request stays driven so consecutive calls pipeline
  task automatic bank_op(input logic we, input logic [BANK_ADDR_W-1:0] addr,
                         input logic [BANK_DATA_W-1:0] wdata);
    logic [BANK_DATA_W-1:0] exp_rdata;

    bank_req   = 1'b1;
    bank_we    = we;
    bank_addr  = addr;
    bank_wdata = wdata;
    wait_grant();
    if (we) begin
      mem_model[addr] = wdata ^ xor_pad(key_model, nonce_model, addr);
    end
    exp_rdata = mem_model[addr] ^ xor_pad(key_model, nonce_model, addr);
    @(negedge clk);
    if (we) begin
      check_value("no read data after a write", bank_rvalid, 1'b0);
    end else begin
      check_value("read data one cycle after grant", bank_rvalid, 1'b1);
      check_value("read data against model", bank_rdata, exp_rdata);
      last_rdata = bank_rdata;
    end
  endtask

  task automatic bank_idle();
    bank_req = 1'b0;
    bank_we  = 1'b0;
    @(negedge clk);
    check_value("read data lasts a single cycle", bank_rvalid, 1'b0);
  endtask

  task automatic invalidate_key();
    check_value("no rekey pending before invalidation", scramble_req, 1'b0);
    icache_inval = 1'b1;
    @(negedge clk);
    icache_inval = 1'b0;
    check_value("rekey request after invalidation", scramble_req, 1'b1);
    // Requests against the fenced bank are dropped
    bank_req  = 1'b1;
    bank_we   = 1'b0;
    bank_addr = '0;
    repeat (2) begin
      #SETTLE;
      check_value("no grant while key invalid", bank_gnt, 1'b0);
      @(negedge clk);
      check_value("no read data for a lost request", bank_rvalid, 1'b0);
      check_value("rekey request still pending", scramble_req, 1'b1);
    end
    bank_req = 1'b0;
  endtask

  task automatic deliver_key(input logic [SCR_KEY_W-1:0] key,
                             input logic [SCR_NONCE_W-1:0] nonce);
    int tries;

    tries = 0;
    while (!scramble_req) begin
      @(negedge clk);
      tries++;
      if (tries > TIMEOUT_CYCLES) begin
        abort_run("scramble_req_o never rose before the key delivery");
      end
    end
    scramble_key_valid = 1'b1;
    scramble_key       = key;
    scramble_nonce     = nonce;
    bank_req           = 1'b1;
    bank_we            = 1'b0;
    bank_addr          = '0;
    #SETTLE;
    check_value("no grant in the delivery cycle", bank_gnt, 1'b0);
    @(negedge clk);
    scramble_key_valid = 1'b0;
    key_model          = key;
    nonce_model        = nonce;
    check_value("rekey request drops after delivery", scramble_req, 1'b0);
    check_value("no read data for a lost request", bank_rvalid, 1'b0);
    #SETTLE;
    check_value("grant resumes with the new key", bank_gnt, 1'b1);
    @(negedge clk);
    check_value("read data after rekey", bank_rvalid, 1'b1);
    check_value("rekey read against model", bank_rdata,
                mem_model[0] ^ xor_pad(key_model, nonce_model, '0));
    bank_idle();
  endtask

  // Bits are busy, debug, irq pending, nmi
  task automatic set_wake(input logic [3:0] bits, input logic exp_file);
    logic exp_now;
    logic exp_next;

    {core_busy, debug_req, irq_pending, irq_nm} = bits;
    exp_now  = ~(busy_model | bits[2] | bits[1] | bits[0]);
    exp_next = ~(bits[3] | bits[2] | bits[1] | bits[0]);
    #SETTLE;
    check_value("sleep before busy is registered", core_sleep, exp_now);
    @(negedge clk);
    busy_model = bits[3];
    check_value("sleep against model", core_sleep, exp_next);
    check_value("sleep against cases file", core_sleep, exp_file);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int           fd;
    int           fields;
    int           tries;
    string        line;
    logic [7:0]   op;
    logic [127:0] arg_a;
    logic [127:0] arg_b;
    logic [127:0] arg_c;

    icache_inval       = 1'b0;
    scramble_key_valid = 1'b0;
    scramble_key       = '0;
    scramble_nonce     = '0;
    bank_req           = 1'b0;
    bank_we            = 1'b0;
    bank_addr          = '0;
    bank_wdata         = '0;
    core_busy          = 1'b0;
    debug_req          = 1'b0;
    irq_pending        = 1'b0;
    irq_nm             = 1'b0;
    key_model          = RESET_KEY;
    nonce_model        = RESET_NONCE;
    busy_model         = 1'b0;
    error_count        = 0;
    seed               = 32'h168c_f53a;

    tries = 0;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      tries++;
      if (tries > TIMEOUT_CYCLES) begin
        abort_run("reset was never released");
      end
    end
    @(negedge clk);
    check_value("no rekey request after reset", scramble_req, 1'b0);
    check_value("no read data after reset", bank_rvalid, 1'b0);
    check_value("sleep with all wake sources low", core_sleep, 1'b1);

    fd = $fopen("sim/scr_cases.txt", "r");
    if (fd == 0) begin
      abort_run("could not open sim/scr_cases.txt");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      fields = $sscanf(line, "%c %h %h %h", op, arg_a, arg_b, arg_c);
      if (fields != 4) begin
        abort_run({"malformed line in cases file: ", line});
      end
      case (op)
        "W": begin
          bank_op(1'b1, arg_a[BANK_ADDR_W-1:0], arg_b[BANK_DATA_W-1:0]);
          bank_idle();
        end
        "R": begin
          bank_op(1'b0, arg_a[BANK_ADDR_W-1:0], '0);
          check_value("read data against cases file", last_rdata, arg_c);
          bank_idle();
        end
        "I": invalidate_key();
        "K": deliver_key(arg_a, arg_b[SCR_NONCE_W-1:0]);
        "S": set_wake(arg_a[3:0], arg_c[0]);
        default: abort_run({"unknown operation in cases file: ", line});
      endcase
    end
    $fclose(fd);

    // Random burst over the whole bank, writes then back-to-back reads
    for (int a = 0; a < BANK_DEPTH; a++) begin
      bank_op(1'b1, BANK_ADDR_W'(a), $random(seed));
    end
    bank_idle();
    for (int a = 0; a < BANK_DEPTH; a++) begin
      bank_op(1'b0, BANK_ADDR_W'(a), '0);
    end
    bank_idle();

    if (error_count == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      abort_run("checks reported mismatches");
    end
  end

endmodule

//--- sim/scr_cases.txt
# op a b c, hex: W addr data 0 | R addr 0 expected | I 0 0 0 | K key nonce 0
# S wake(busy,debug,irq,nmi) 0 expected_sleep
W 0 12345678 0
W 1 cafef00d 0
W 5 a5a5a5a5 0
R 0 0 12345678
R 1 0 cafef00d
R 5 0 a5a5a5a5
S 0 0 1
S 8 0 0
S 0 0 1
S 4 0 0
S 2 0 0
S 1 0 0
S 0 0 1
I 0 0 0
K 3c5a9e17d2b46f0881c35e7a0b62f2b9 7a1ec3905b2d84f6 0
R 0 0 12cb5687
R 1 0 ca01f0f2
R 5 0 a55aa55a
W 2 0badbeef 0
R 2 0 0badbeef
I 0 0 0
K 3c5a9e17d2b46f0881c35e7a0b62f2b9 7a1ec3904a3c95e7 0
R 2 0 1abcaffe
R 0 0 03da4796

//--- tb.f
src/scr_pkg.sv
src/scr_key_mgr.sv
src/scr_ram_bank.sv
src/scr_top.sv
sim/tb_clk_gen.sv
sim/tb_top.sv

//--- Bender.yml
package:
  name: scr_top

dependencies: {}

sources:
  # RTL, package first
  - src/scr_pkg.sv
  - src/scr_key_mgr.sv
  - src/scr_ram_bank.sv
  - src/scr_top.sv

  # Testbench
  - target: simulation
    files:
      - sim/tb_clk_gen.sv
      - sim/tb_top.sv
